/* all.f */
+incdir+.
rv_core_pkg.sv
rv_decoder.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f all.f --top-module tb_rv_core -o sim_rv_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_rv_core > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation run returned an error"
    exit 1
fi

cat sim.log
if grep -q "Simulation PASSED" sim.log; then
    exit 0
fi
exit 1

/* rv_core_params.svh */
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Data path width
`define RV_XLEN     32

// Register file geometry
`define RV_REG_W    5
`define RV_NUM_REGS 32

`endif

/* rv_core_pkg.sv */
`include "rv_core_params.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]  xlen_t;
    typedef logic [31:0]          instr_t;
    typedef logic [`RV_REG_W-1:0] reg_addr_t;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_FENCE  = 7'b0001111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        DEC_R, DEC_I, DEC_S, DEC_B, DEC_U, DEC_J, DEC_NONE
    } dec_fmt_t;

    // Writing ops form one contiguous range from OP_ADD to OP_JALR
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_LOAD, OP_STORE, OP_BRANCH, OP_FENCE, OP_SYSTEM
    } op_t;

    // First decode stage register
    typedef struct packed {
        logic     valid;
        dec_fmt_t fmt;
        logic     illegal;
        instr_t   instr;
        xlen_t    pc;
    } dec_s1_t;

    typedef struct packed {
        logic      valid;
        op_t       op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     imm;
        xlen_t     pc;
        logic      illegal;
    } decoded_t;

    typedef struct packed {
        logic      valid;
        logic      we;
        reg_addr_t rd;
        xlen_t     data;
        logic      illegal;
    } exec_result_t;

endpackage

/* rv_core_top.sv */
`timescale 1ns/100ps

module rv_core_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_stall,
    input  logic                   i_valid,
    input  rv_core_pkg::instr_t    i_instr,
    input  rv_core_pkg::xlen_t     i_pc,
    output logic                   o_wb_valid,
    output rv_core_pkg::reg_addr_t o_wb_rd,
    output rv_core_pkg::xlen_t     o_wb_data,
    output logic                   o_illegal
);

    rv_core_pkg::decoded_t     dec;
    rv_core_pkg::exec_result_t res;
    rv_core_pkg::reg_addr_t    rs1;
    rv_core_pkg::reg_addr_t    rs2;
    rv_core_pkg::xlen_t        rs1_val;
    rv_core_pkg::xlen_t        rs2_val;
    logic                      fwd_we;
    rv_core_pkg::reg_addr_t    fwd_rd;
    rv_core_pkg::xlen_t        fwd_data;

    rv_decoder u_decoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_stall (i_stall),
        .i_valid (i_valid),
        .i_instr (i_instr),
        .i_pc    (i_pc),
        .o_dec   (dec)
    );

    rv_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_stall    (i_stall),
        .i_dec      (dec),
        .i_rs1_val  (rs1_val),
        .i_rs2_val  (rs2_val),
        .i_fwd_we   (fwd_we),
        .i_fwd_rd   (fwd_rd),
        .i_fwd_data (fwd_data),
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .o_res      (res)
    );

    rv_result u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_stall    (i_stall),
        .i_res      (res),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .o_rs1_val  (rs1_val),
        .o_rs2_val  (rs2_val),
        .o_fwd_we   (fwd_we),
        .o_fwd_rd   (fwd_rd),
        .o_fwd_data (fwd_data),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data),
        .o_illegal  (o_illegal)
    );

endmodule

/* rv_decoder.sv */
`timescale 1ns/100ps

module rv_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_stall,
    input  logic                  i_valid,
    input  rv_core_pkg::instr_t   i_instr,
    input  rv_core_pkg::xlen_t    i_pc,
    output rv_core_pkg::decoded_t o_dec
);

    rv_core_pkg::dec_fmt_t fmt_sel;
    logic                  fmt_bad;
    rv_core_pkg::dec_s1_t  s1;
    rv_core_pkg::decoded_t dec_d;
    logic                  bad;
    logic [2:0]            f3;
    logic [6:0]            f7;

    always_comb begin
        fmt_sel = rv_core_pkg::DEC_NONE;
        fmt_bad = 1'b0;
        case (i_instr[6:0])
            rv_core_pkg::OPC_OP:     fmt_sel = rv_core_pkg::DEC_R;
            rv_core_pkg::OPC_OP_IMM,
            rv_core_pkg::OPC_LOAD,
            rv_core_pkg::OPC_JALR,
            rv_core_pkg::OPC_FENCE,
            rv_core_pkg::OPC_SYSTEM: fmt_sel = rv_core_pkg::DEC_I;
            rv_core_pkg::OPC_STORE:  fmt_sel = rv_core_pkg::DEC_S;
            rv_core_pkg::OPC_BRANCH: fmt_sel = rv_core_pkg::DEC_B;
            rv_core_pkg::OPC_LUI,
            rv_core_pkg::OPC_AUIPC:  fmt_sel = rv_core_pkg::DEC_U;
            rv_core_pkg::OPC_JAL:    fmt_sel = rv_core_pkg::DEC_J;
            default:                 fmt_bad = 1'b1; // Unknown major opcode
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1 <= '0;
        end else if (!i_stall) begin
            s1.valid   <= i_valid;
            s1.fmt     <= fmt_sel;
            s1.illegal <= fmt_bad;
            s1.instr   <= i_instr;
            s1.pc      <= i_pc;
        end
    end

    assign f3 = s1.instr[14:12];
    assign f7 = s1.instr[31:25];

    always_comb begin
        dec_d       = '0;
        dec_d.valid = s1.valid;
        dec_d.pc    = s1.pc;
        dec_d.op    = rv_core_pkg::OP_NOP;
        bad         = s1.illegal;
        if (s1.valid) begin
            case (s1.fmt)
                rv_core_pkg::DEC_R: begin
                    dec_d.rd  = s1.instr[11:7];
                    dec_d.rs1 = s1.instr[19:15];
                    dec_d.rs2 = s1.instr[24:20];
                    if (f7 == 7'b0000000) begin
                        case (f3)
                            3'b000:  dec_d.op = rv_core_pkg::OP_ADD;
                            3'b001:  dec_d.op = rv_core_pkg::OP_SLL;
                            3'b010:  dec_d.op = rv_core_pkg::OP_SLT;
                            3'b011:  dec_d.op = rv_core_pkg::OP_SLTU;
                            3'b100:  dec_d.op = rv_core_pkg::OP_XOR;
                            3'b101:  dec_d.op = rv_core_pkg::OP_SRL;
                            3'b110:  dec_d.op = rv_core_pkg::OP_OR;
                            default: dec_d.op = rv_core_pkg::OP_AND;
                        endcase
                    end else if (f7 == 7'b0100000 && f3 == 3'b000) begin
                        dec_d.op = rv_core_pkg::OP_SUB;
                    end else if (f7 == 7'b0100000 && f3 == 3'b101) begin
                        dec_d.op = rv_core_pkg::OP_SRA;
                    end else begin
                        bad = 1'b1; // M extension lands here too
                    end
                end
                rv_core_pkg::DEC_I: begin
                    dec_d.rd  = s1.instr[11:7];
                    dec_d.rs1 = s1.instr[19:15];
                    dec_d.imm = {{20{s1.instr[31]}}, s1.instr[31:20]};
                    case (s1.instr[6:0])
                        rv_core_pkg::OPC_OP_IMM: begin
                            case (f3)
                                3'b000: dec_d.op = rv_core_pkg::OP_ADDI;
                                3'b010: dec_d.op = rv_core_pkg::OP_SLTI;
                                3'b011: dec_d.op = rv_core_pkg::OP_SLTIU;
                                3'b100: dec_d.op = rv_core_pkg::OP_XORI;
                                3'b110: dec_d.op = rv_core_pkg::OP_ORI;
                                3'b111: dec_d.op = rv_core_pkg::OP_ANDI;
                                3'b001: begin
                                    dec_d.op = rv_core_pkg::OP_SLLI;
                                    bad      = (f7 != 7'b0000000);
                                end
                                default: begin
                                    if (f7 == 7'b0000000) begin
                                        dec_d.op = rv_core_pkg::OP_SRLI;
                                    end else if (f7 == 7'b0100000) begin
                                        dec_d.op = rv_core_pkg::OP_SRAI;
                                    end else begin
                                        bad = 1'b1;
                                    end
                                end
                            endcase
                        end
                        rv_core_pkg::OPC_LOAD: begin
                            dec_d.op = rv_core_pkg::OP_LOAD;
                            bad      = (f3 == 3'b011) || (f3[2:1] == 2'b11);
                        end
                        rv_core_pkg::OPC_JALR: begin
                            dec_d.op = rv_core_pkg::OP_JALR;
                            bad      = (f3 != 3'b000);
                        end
                        rv_core_pkg::OPC_FENCE: begin
                            dec_d.op = rv_core_pkg::OP_FENCE;
                            bad      = (f3 != 3'b000);
                        end
                        default: begin // SYSTEM and CSR group
                            dec_d.op = rv_core_pkg::OP_SYSTEM;
                            if (f3 == 3'b100) begin
                                bad = 1'b1;
                            end else if (f3 == 3'b000) begin
                                bad = !(s1.instr[31:20] inside {12'h000, 12'h001, 12'h302});
                            end
                        end
                    endcase
                end
                rv_core_pkg::DEC_S: begin
                    dec_d.rs1 = s1.instr[19:15];
                    dec_d.rs2 = s1.instr[24:20];
                    dec_d.imm = {{20{s1.instr[31]}}, f7, s1.instr[11:7]};
                    dec_d.op  = rv_core_pkg::OP_STORE;
                    bad       = (f3 > 3'b010);
                end
                rv_core_pkg::DEC_B: begin
                    dec_d.rs1 = s1.instr[19:15];
                    dec_d.rs2 = s1.instr[24:20];
                    dec_d.imm = {{20{s1.instr[31]}}, s1.instr[7], s1.instr[30:25],
                                 s1.instr[11:8], 1'b0};
                    dec_d.op  = rv_core_pkg::OP_BRANCH;
                    bad       = (f3[2:1] == 2'b01);
                end
                rv_core_pkg::DEC_U: begin
                    dec_d.rd  = s1.instr[11:7];
                    dec_d.imm = {s1.instr[31:12], 12'b0};
                    dec_d.op  = (s1.instr[5]) ? rv_core_pkg::OP_LUI : rv_core_pkg::OP_AUIPC;
                end
                rv_core_pkg::DEC_J: begin
                    dec_d.rd  = s1.instr[11:7];
                    dec_d.imm = {{12{s1.instr[31]}}, s1.instr[19:12], s1.instr[20],
                                 s1.instr[30:21], 1'b0};
                    dec_d.op  = rv_core_pkg::OP_JAL;
                end
                default: bad = 1'b1;
            endcase
        end
        if (bad) begin
            dec_d.op = rv_core_pkg::OP_NOP; // Illegal retires as a bubble
            dec_d.rd = '0;
        end
        dec_d.illegal = s1.valid & bad;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_dec <= '0;
        end else if (!i_stall) begin
            o_dec <= dec_d;
        end
    end

    // A legal instruction always resolves to a real op
    a_illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        o_dec.valid |-> (o_dec.illegal == (o_dec.op == rv_core_pkg::OP_NOP)));

endmodule

/* rv_execute.sv */
`timescale 1ns/100ps

module rv_execute (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_stall,
    input  rv_core_pkg::decoded_t     i_dec,
    input  rv_core_pkg::xlen_t        i_rs1_val,
    input  rv_core_pkg::xlen_t        i_rs2_val,
    input  logic                      i_fwd_we,
    input  rv_core_pkg::reg_addr_t    i_fwd_rd,
    input  rv_core_pkg::xlen_t        i_fwd_data,
    output rv_core_pkg::reg_addr_t    o_rs1,
    output rv_core_pkg::reg_addr_t    o_rs2,
    output rv_core_pkg::exec_result_t o_res
);

    rv_core_pkg::xlen_t op_a;
    rv_core_pkg::xlen_t rs2_v;
    rv_core_pkg::xlen_t op_b;
    rv_core_pkg::xlen_t result;
    logic               writes;

    assign o_rs1 = i_dec.rs1;
    assign o_rs2 = i_dec.rs2;

    // Pending write in the result stage wins over the register file
    assign op_a  = (i_fwd_we && i_fwd_rd == i_dec.rs1 && i_dec.rs1 != '0) ?
                   i_fwd_data : i_rs1_val;
    assign rs2_v = (i_fwd_we && i_fwd_rd == i_dec.rs2 && i_dec.rs2 != '0) ?
                   i_fwd_data : i_rs2_val;
    assign op_b  = (i_dec.op >= rv_core_pkg::OP_ADDI) ? i_dec.imm : rs2_v;

    assign writes = (i_dec.op >= rv_core_pkg::OP_ADD) && (i_dec.op <= rv_core_pkg::OP_JALR);

    always_comb begin
        case (i_dec.op)
            rv_core_pkg::OP_ADD,
            rv_core_pkg::OP_ADDI:  result = op_a + op_b;
            rv_core_pkg::OP_SUB:   result = op_a - op_b;
            rv_core_pkg::OP_SLL,
            rv_core_pkg::OP_SLLI:  result = op_a << op_b[4:0];
            rv_core_pkg::OP_SLT,
            rv_core_pkg::OP_SLTI:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_core_pkg::OP_SLTU,
            rv_core_pkg::OP_SLTIU: result = {31'b0, op_a < op_b};
            rv_core_pkg::OP_XOR,
            rv_core_pkg::OP_XORI:  result = op_a ^ op_b;
            rv_core_pkg::OP_SRL,
            rv_core_pkg::OP_SRLI:  result = op_a >> op_b[4:0];
            rv_core_pkg::OP_SRA,
            rv_core_pkg::OP_SRAI:  result = $signed(op_a) >>> op_b[4:0];
            rv_core_pkg::OP_OR,
            rv_core_pkg::OP_ORI:   result = op_a | op_b;
            rv_core_pkg::OP_AND,
            rv_core_pkg::OP_ANDI:  result = op_a & op_b;
            rv_core_pkg::OP_LUI:   result = i_dec.imm;
            rv_core_pkg::OP_AUIPC: result = i_dec.pc + i_dec.imm;
            rv_core_pkg::OP_JAL,
            rv_core_pkg::OP_JALR:  result = i_dec.pc + 32'd4; // Link address only
            default:               result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_res <= '0;
        end else if (!i_stall) begin
            o_res.valid   <= i_dec.valid;
            o_res.we      <= i_dec.valid && writes && i_dec.rd != '0;
            o_res.rd      <= i_dec.rd;
            o_res.data    <= result;
            o_res.illegal <= i_dec.valid && i_dec.illegal;
        end
    end

    a_we_not_illegal: assert property (@(posedge clk) disable iff (!rst_n)
        o_res.valid |-> !(o_res.we && o_res.illegal));

endmodule

/* rv_result.sv */
`timescale 1ns/100ps
`include "rv_core_params.svh"

module rv_result (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_stall,
    input  rv_core_pkg::exec_result_t i_res,
    input  rv_core_pkg::reg_addr_t    i_rs1,
    input  rv_core_pkg::reg_addr_t    i_rs2,
    output rv_core_pkg::xlen_t        o_rs1_val,
    output rv_core_pkg::xlen_t        o_rs2_val,
    output logic                      o_fwd_we,
    output rv_core_pkg::reg_addr_t    o_fwd_rd,
    output rv_core_pkg::xlen_t        o_fwd_data,
    output logic                      o_wb_valid,
    output rv_core_pkg::reg_addr_t    o_wb_rd,
    output rv_core_pkg::xlen_t        o_wb_data,
    output logic                      o_illegal
);

    rv_core_pkg::xlen_t regs [`RV_NUM_REGS];

    assign o_wb_valid = i_res.valid && i_res.we && !i_stall;
    assign o_wb_rd    = i_res.rd;
    assign o_wb_data  = i_res.data;
    assign o_illegal  = i_res.valid && i_res.illegal && !i_stall;

    // Same write seen one cycle early by execute
    assign o_fwd_we   = o_wb_valid;
    assign o_fwd_rd   = i_res.rd;
    assign o_fwd_data = i_res.data;

    assign o_rs1_val = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_val = (i_rs2 == '0) ? '0 : regs[i_rs2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (o_wb_valid) begin
            regs[o_wb_rd] <= o_wb_data;
        end
    end

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        o_wb_valid |-> o_wb_rd != '0);

endmodule

/* tb_rv_core.sv */
`timescale 1ns/100ps
`include "rv_core_params.svh"

module tb_rv_core;

    localparam int N_DIRECTED = 18;
    localparam int N_RAND_A   = 200;
    localparam int N_RAND_B   = 300;
    localparam int N_TOTAL    = N_DIRECTED + N_RAND_A + N_RAND_B;
    localparam int TIMEOUT_CYC = N_TOTAL * 12 + 16;

    typedef struct packed {
        logic [1:0]             kind; // 0 none, 1 write, 2 illegal
        rv_core_pkg::reg_addr_t rd;
        rv_core_pkg::xlen_t     data;
    } expect_t;

    logic                   clk;
    logic                   rst_n;
    logic                   i_stall;
    logic                   i_valid;
    rv_core_pkg::instr_t    i_instr;
    rv_core_pkg::xlen_t     i_pc;
    logic                   o_wb_valid;
    rv_core_pkg::reg_addr_t o_wb_rd;
    rv_core_pkg::xlen_t     o_wb_data;
    logic                   o_illegal;

    rv_core_pkg::xlen_t shadow [`RV_NUM_REGS];
    expect_t            exp_q [$];
    rv_core_pkg::instr_t directed [$];
    logic [31:0]        lfsr;
    logic [31:0]        pc_next;
    logic               stall_en;
    logic               gap_en;
    int                 errors;
    int                 checks;

    rv_core_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_stall    (i_stall),
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_pc       (i_pc),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data),
        .o_illegal  (o_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic rv_core_pkg::instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                                  input logic [4:0] rs1, input logic [2:0] f3,
                                                  input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_core_pkg::instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                  input logic [2:0] f3, input logic [4:0] rd,
                                                  input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // Expected retirement of one instruction under the RV32I rules
    function automatic expect_t ref_model(input logic [31:0] ins, input logic [31:0] pc);
        expect_t     e;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic        ill;
        logic        wr;
        f3  = ins[14:12];
        f7  = ins[31:25];
        a   = shadow[ins[19:15]];
        b   = shadow[ins[24:20]];
        v   = '0;
        ill = 1'b0;
        wr  = 1'b0;
        if (ins[6:0] == 7'b0010011) begin
            b = {{20{ins[31]}}, ins[31:20]};
        end
        case (ins[6:0])
            7'b0110011, 7'b0010011: begin
                wr = 1'b1;
                case (f3)
                    3'b000: v = (ins[5] && f7 == 7'h20) ? a - b : a + b;
                    3'b001: v = a << b[4:0];
                    3'b010: v = {31'b0, $signed(a) < $signed(b)};
                    3'b011: v = {31'b0, a < b};
                    3'b100: v = a ^ b;
                    3'b101: v = (f7 == 7'h20) ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'b110: v = a | b;
                    default: v = a & b;
                endcase
                if (ins[5]) begin
                    ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
                end else if (f3 == 3'b001) begin
                    ill = (f7 != 7'h00);
                end else if (f3 == 3'b101) begin
                    ill = !(f7 == 7'h00 || f7 == 7'h20);
                end
            end
            7'b0110111: begin
                wr = 1'b1;
                v  = {ins[31:12], 12'b0};
            end
            7'b0010111: begin
                wr = 1'b1;
                v  = pc + {ins[31:12], 12'b0};
            end
            7'b1101111: begin
                wr = 1'b1;
                v  = pc + 32'd4;
            end
            7'b1100111: begin
                wr  = 1'b1;
                v   = pc + 32'd4;
                ill = (f3 != 3'b000);
            end
            7'b0000011: ill = (f3 == 3'b011) || (f3 == 3'b110) || (f3 == 3'b111);
            7'b0100011: ill = (f3 > 3'b010);
            7'b1100011: ill = (f3 == 3'b010) || (f3 == 3'b011);
            7'b0001111: ill = (f3 != 3'b000);
            7'b1110011: ill = (f3 == 3'b100) || (f3 == 3'b000 && ins[31:20] != 12'h000 &&
                              ins[31:20] != 12'h001 && ins[31:20] != 12'h302);
            default: ill = 1'b1;
        endcase
        e.rd   = ins[11:7];
        e.data = v;
        if (ill) begin
            e.kind = 2'd2;
        end else if (wr && ins[11:7] != 5'd0) begin
            e.kind = 2'd1;
        end else begin
            e.kind = 2'd0;
        end
        return e;
    endfunction

    function automatic rv_core_pkg::instr_t gen_instr();
        logic [31:0] r;
        logic [31:0] opc_bits;
        logic [3:0]  cls;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        r   = rand_bits(4);
        cls = r[3:0];
        r   = rand_bits(3);
        rd  = {2'b00, r[2:0]}; // Small register window for dependencies
        r   = rand_bits(3);
        rs1 = {2'b00, r[2:0]};
        r   = rand_bits(3);
        rs2 = {2'b00, r[2:0]};
        r   = rand_bits(3);
        f3  = r[2:0];
        r   = rand_bits(12);
        imm = r[11:0];
        r   = rand_bits(2);
        case (r[1:0])
            2'd2:    f7 = 7'h20;
            2'd3: begin
                r = rand_bits(1);
                if (r[0]) begin
                    f7 = 7'h01; // M ext
                end else begin
                    r  = rand_bits(7);
                    f7 = r[6:0]; // Junk
                end
            end
            default: f7 = 7'h00;
        endcase
        case (cls)
            4'd0, 4'd1, 4'd2, 4'd14: return enc_r(f7, rs2, rs1, f3, rd);
            4'd3, 4'd4, 4'd5, 4'd15: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm[11:5] = f7;
                end
                return enc_i(imm, rs1, f3, rd, 7'b0010011);
            end
            4'd6: begin
                r = rand_bits(20);
                return {r[19:0], rd, 7'b0110111};
            end
            4'd7: begin
                r = rand_bits(20);
                return {r[19:0], rd, 7'b0010111};
            end
            4'd8: begin
                r = rand_bits(20);
                return {r[19:0], rd, 7'b1101111};
            end
            4'd9:  return enc_i(imm, rs1, (f7 == 7'h01) ? f3 : 3'b000, rd, 7'b1100111);
            4'd10: return enc_i(imm, rs1, f3, rd, 7'b0000011);
            4'd11: return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
            4'd12: return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b1100011};
            default: begin
                r = rand_bits(2);
                if (r[1:0] == 2'd0) begin
                    return enc_i(imm, rs1, (f7 == 7'h00) ? 3'b000 : f3, rd, 7'b0001111);
                end else if (r[1:0] == 2'd1) begin
                    if (f7 != 7'h01) begin
                        imm = (f7 == 7'h00) ? 12'h000 : 12'h302;
                    end
                    return enc_i(imm, rs1, f3, rd, 7'b1110011);
                end
                r        = rand_bits(25);
                opc_bits = rand_bits(7);
                return {r[24:0], opc_bits[6:0]}; // Mostly bad opcodes
            end
        endcase
    endfunction

    // Holds the instruction until a cycle with no stall and no gap
    task automatic issue_instr(input rv_core_pkg::instr_t ins);
        logic    done;
        logic    st;
        logic    gap;
        expect_t e;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            st  = stall_en && (rand_bits(2) == 32'd0);
            gap = gap_en && (rand_bits(2) == 32'd0);
            if (st || gap) begin
                i_stall <= st;
                i_valid <= 1'b0;
            end else begin
                i_stall <= 1'b0;
                i_valid <= 1'b1;
                i_instr <= ins;
                i_pc    <= pc_next;
                e = ref_model(ins, pc_next);
                if (e.kind == 2'd1) begin
                    shadow[e.rd] = e.data;
                end
                if (e.kind != 2'd0) begin
                    exp_q.push_back(e);
                end
                pc_next = pc_next + 32'd4;
                done    = 1'b1;
            end
        end
    endtask

    task automatic drain_and_report(input string name, input int n, input int err_before);
        int wait_cyc;
        @(posedge clk);
        i_valid  <= 1'b0;
        i_stall  <= 1'b0;
        wait_cyc = 0;
        while (exp_q.size() != 0 && wait_cyc < 40) begin
            @(posedge clk);
            wait_cyc++;
        end
        repeat (6) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0t: %0d expected results never came out", $time, exp_q.size());
            errors += exp_q.size();
            exp_q.delete();
        end
        $display("test %s: %0d instructions, %0d errors", name, n, errors - err_before);
    endtask

    // Comparator samples after the outputs settle
    always @(negedge clk) begin
        expect_t e;
        if (rst_n && (o_wb_valid || o_illegal)) begin
            if (exp_q.size() == 0) begin
                $display("%0t: output seen with no instruction expecting one (rd %0d)",
                         $time, o_wb_rd);
                errors++;
            end else begin
                e = exp_q.pop_front();
                checks++;
                if (o_illegal != (e.kind == 2'd2)) begin
                    $display("FAILED %0t o_illegal exp %0b got %0b", $time, e.kind == 2'd2,
                             o_illegal);
                    errors++;
                end else if (o_wb_valid) begin
                    if (o_wb_rd != e.rd) begin
                        $display("FAILED %0t o_wb_rd exp %0d got %0d", $time, e.rd, o_wb_rd);
                        errors++;
                    end
                    if (o_wb_data != e.data) begin
                        $display("FAILED %0t o_wb_data exp %h got %h", $time, e.data, o_wb_data);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYC * 8);
        $display("Watchdog expired after %0d cycles, pipeline stopped retiring", TIMEOUT_CYC);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int err0;
        rst_n    = 1'b0;
        i_stall  = 1'b0;
        i_valid  = 1'b0;
        i_instr  = '0;
        i_pc     = '0;
        lfsr     = 32'd89663;
        pc_next  = 32'h0000_1000;
        stall_en = 1'b0;
        gap_en   = 1'b0;
        errors   = 0;
        checks   = 0;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        directed.push_back(enc_i(12'hffb, 5'd0, 3'b000, 5'd1, 7'b0010011));
        directed.push_back(enc_i(12'h007, 5'd1, 3'b000, 5'd2, 7'b0010011)); // Bypass on x1
        directed.push_back(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));
        directed.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd4));
        directed.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd5));
        directed.push_back(enc_i(12'h403, 5'd1, 3'b101, 5'd6, 7'b0010011));
        directed.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd7));
        directed.push_back(enc_i(12'h001, 5'd1, 3'b011, 5'd3, 7'b0010011));
        directed.push_back(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd0)); // x0 stays zero
        directed.push_back(enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd7));
        directed.push_back({20'habcde, 5'd1, 7'b0110111});
        directed.push_back({20'h12345, 5'd2, 7'b0010111});
        directed.push_back({20'h00100, 5'd3, 7'b1101111});
        directed.push_back(enc_i(12'h000, 5'd1, 3'b000, 5'd4, 7'b1100111));
        directed.push_back(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd5));
        directed.push_back(32'h0000_000b);
        directed.push_back(enc_i(12'h000, 5'd1, 3'b010, 5'd6, 7'b0000011));
        directed.push_back(32'h0000_0073);
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        err0 = errors;
        foreach (directed[i]) begin
            issue_instr(directed[i]);
        end
        drain_and_report("directed", N_DIRECTED, err0);

        err0 = errors;
        for (int i = 0; i < N_RAND_A; i++) begin
            issue_instr(gen_instr());
        end
        drain_and_report("random_back_to_back", N_RAND_A, err0);

        err0     = errors;
        stall_en = 1'b1;
        gap_en   = 1'b1;
        for (int i = 0; i < N_RAND_B; i++) begin
            issue_instr(gen_instr());
        end
        drain_and_report("random_stall_gap", N_RAND_B, err0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
